/* hdl/zrl_stream_pkg.sv */
`default_nettype none

package zrl_stream_pkg;

    localparam int LANES = 4;  // characters per word

    typedef logic [7:0] char_t;
    typedef char_t [LANES-1:0] word_t;  // lane 0 in the low byte

    typedef struct packed {
        word_t data;
        logic  last;
    } in_beat_t;

    typedef struct packed {
        char_t ch;
        logic  last;
    } char_beat_t;

    typedef struct packed {
        word_t            data;
        logic [LANES-1:0] keep;  // bit 0 is lane 0
        logic             last;
    } out_beat_t;

endpackage

`default_nettype wire

/* hdl/zrl_code_pkg.sv */
`default_nettype none

package zrl_code_pkg;

    localparam logic [7:0] ZERO_CHAR = 8'h30;  // ascii "0"
    localparam logic [7:0] RUN_END   = 8'h07;

    localparam int COUNT_W    = 24;
    localparam int RUN_DIGITS = 7;

    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [RUN_DIGITS-1:0][3:0] digits_t;  // digit 0 is the units

    localparam count_t RUN_MAX = 24'd9_999_999;  // largest 7-digit count

    // encoder FSM
    typedef enum logic [2:0] {
        IDLE,
        COUNT,
        CONVERT,
        EMIT_ZERO,
        EMIT_DIGITS,
        EMIT_END,
        EMIT_LIT
    } enc_state_t;

endpackage

`default_nettype wire

/* hdl/zrl_word_unpacker.sv */
`default_nettype none

module zrl_word_unpacker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  zrl_stream_pkg::in_beat_t   in_beat,
    output logic                       char_valid,
    input  logic                       char_ready,
    output zrl_stream_pkg::char_beat_t char_beat
);
    import zrl_stream_pkg::*;

    in_beat_t                   held;
    logic                       full;
    logic [$clog2(LANES)-1:0]   lane;

    assign in_ready   = !full;
    assign char_valid = full;

    // last belongs to the final lane only
    assign char_beat = '{ch: held.data[lane], last: held.last && (lane == LANES - 1)};

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
            lane <= '0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
            lane <= '0;
        end else if (char_valid && char_ready) begin
            if (lane == LANES - 1) begin
                full <= 1'b0;  // word drained
            end
            lane <= lane + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held <= in_beat;
        end
    end

endmodule

`default_nettype wire

/* hdl/zrl_decimal_digits.sv */
`default_nettype none

module zrl_decimal_digits (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  zrl_code_pkg::count_t  count,
    output logic                  done,
    output zrl_code_pkg::digits_t digits,
    output logic [2:0]            ndigits
);
    import zrl_code_pkg::*;

    count_t                       shreg;
    digits_t                      adj;
    logic                         busy;
    logic [$clog2(COUNT_W)-1:0]   bit_cnt;

    // add 3 to every digit of 5 or more before the shift
    always_comb begin
        adj = digits;
        for (int i = 0; i < RUN_DIGITS; i++) begin
            if (adj[i] >= 4'd5) begin
                adj[i] = adj[i] + 4'd3;
            end
        end
    end

    always_comb begin
        ndigits = 3'd1;  // a count of zero still shows one digit
        for (int i = 1; i < RUN_DIGITS; i++) begin
            if (digits[i] != 4'd0) begin
                ndigits = 3'(i + 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == COUNT_W - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            shreg  <= count;
            digits <= '0;
        end else if (busy) begin
            digits <= {adj[RUN_DIGITS-1][2:0], adj[RUN_DIGITS-2:0], shreg[COUNT_W-1]};
            shreg  <= {shreg[COUNT_W-2:0], 1'b0};  // msb first
        end
    end

endmodule

`default_nettype wire

/* hdl/zrl_run_encoder.sv */
`default_nettype none

module zrl_run_encoder (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       char_valid,
    output logic                       char_ready,
    input  zrl_stream_pkg::char_beat_t char_beat,
    output logic                       byte_valid,
    input  logic                       byte_ready,
    output zrl_stream_pkg::char_beat_t byte_beat
);
    import zrl_stream_pkg::*;
    import zrl_code_pkg::*;

    enc_state_t state;
    count_t     count;
    count_t     count_inc;
    char_t      lit;
    logic       lit_last;
    logic       lit_pending;
    logic       tok_last;
    logic [2:0] digit_idx;
    logic       char_take;
    logic       is_zero;
    logic       conv_start;
    count_t     conv_count;
    logic       conv_done;
    digits_t    conv_digits;
    logic [2:0] conv_ndigits;

    zrl_decimal_digits u_digits (
        .clk     (clk),
        .rst     (rst),
        .start   (conv_start),
        .count   (conv_count),
        .done    (conv_done),
        .digits  (conv_digits),
        .ndigits (conv_ndigits)
    );

    assign char_ready = (state == IDLE) || (state == COUNT);
    assign char_take  = char_valid && char_ready;
    assign is_zero    = char_beat.ch == ZERO_CHAR;
    assign count_inc  = count + 1'b1;

    // a run closes on a literal, at RUN_MAX or at the end of the frame
    always_comb begin
        conv_start = 1'b0;
        conv_count = count;
        if (char_take) begin
            if (is_zero) begin
                conv_start = (count_inc == RUN_MAX) || char_beat.last;
                conv_count = count_inc;
            end else begin
                conv_start = state == COUNT;
            end
        end
    end

    always_comb begin
        byte_valid = 1'b1;
        case (state)
            EMIT_ZERO:   byte_beat = '{ch: ZERO_CHAR, last: 1'b0};
            EMIT_DIGITS: byte_beat = '{ch: ZERO_CHAR | {4'h0, conv_digits[digit_idx]}, last: 1'b0};
            EMIT_END:    byte_beat = '{ch: RUN_END, last: tok_last};
            EMIT_LIT:    byte_beat = '{ch: lit, last: lit_last};
            default: begin
                byte_valid = 1'b0;
                byte_beat  = '{ch: lit, last: 1'b0};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            count       <= '0;
            lit_pending <= 1'b0;
            tok_last    <= 1'b0;
            digit_idx   <= '0;
        end else begin
            case (state)
                IDLE, COUNT: begin
                    if (conv_start) begin
                        state       <= CONVERT;
                        count       <= '0;
                        lit_pending <= !is_zero;  // literal waits behind the token
                        tok_last    <= is_zero && char_beat.last;
                    end else if (char_take && is_zero) begin
                        state <= COUNT;
                        count <= count_inc;
                    end else if (char_take) begin
                        state <= EMIT_LIT;
                    end
                end
                CONVERT: begin
                    if (conv_done) begin
                        state     <= EMIT_ZERO;
                        digit_idx <= '0;
                    end
                end
                EMIT_ZERO: begin
                    if (byte_ready) begin
                        state <= EMIT_DIGITS;
                    end
                end
                EMIT_DIGITS: begin
                    if (byte_ready) begin
                        if (digit_idx == conv_ndigits - 3'd1) begin
                            state <= EMIT_END;
                        end else begin
                            digit_idx <= digit_idx + 3'd1;  // units first
                        end
                    end
                end
                EMIT_END: begin
                    if (byte_ready) begin
                        state <= lit_pending ? EMIT_LIT : IDLE;
                    end
                end
                EMIT_LIT: begin
                    if (byte_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (char_take && !is_zero) begin
            lit      <= char_beat.ch;
            lit_last <= char_beat.last;
        end
    end

endmodule

`default_nettype wire

/* hdl/zrl_byte_packer.sv */
`default_nettype none

module zrl_byte_packer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       byte_valid,
    output logic                       byte_ready,
    input  zrl_stream_pkg::char_beat_t byte_beat,
    output logic                       out_valid,
    input  logic                       out_ready,
    output zrl_stream_pkg::out_beat_t  out_beat
);
    import zrl_stream_pkg::*;

    word_t                    data_q;
    logic [LANES-1:0]         keep_q;
    logic                     last_q;
    logic [$clog2(LANES)-1:0] fill;
    logic                     byte_take;

    assign byte_ready = !out_valid;  // stall while a word waits
    assign byte_take  = byte_valid && byte_ready;
    assign out_beat   = '{data: data_q, keep: keep_q, last: last_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            fill      <= '0;
            keep_q    <= '0;
            last_q    <= 1'b0;
        end else if (out_valid) begin
            if (out_ready) begin
                out_valid <= 1'b0;
            end
        end else if (byte_take) begin
            for (int i = 0; i < LANES; i++) begin
                if (i == fill) begin
                    keep_q[i] <= 1'b1;
                end else if (fill == '0) begin
                    keep_q[i] <= 1'b0;  // fresh word
                end
            end
            last_q <= byte_beat.last;
            if ((fill == LANES - 1) || byte_beat.last) begin
                out_valid <= 1'b1;
                fill      <= '0;
            end else begin
                fill <= fill + 1'b1;
            end
        end
    end

    // unused lanes read as zero
    always_ff @(posedge clk) begin
        if (byte_take) begin
            for (int i = 0; i < LANES; i++) begin
                if (i == fill) begin
                    data_q[i] <= byte_beat.ch;
                end else if (fill == '0) begin
                    data_q[i] <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/zrl_coder_top.sv */
`default_nettype none

module zrl_coder_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  zrl_stream_pkg::in_beat_t  in_beat,
    output logic                      out_valid,
    input  logic                      out_ready,
    output zrl_stream_pkg::out_beat_t out_beat
);
    import zrl_stream_pkg::*;

    logic       char_valid;
    logic       char_ready;
    char_beat_t char_beat;
    logic       byte_valid;
    logic       byte_ready;
    char_beat_t byte_beat;

    zrl_word_unpacker u_unpacker (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_beat    (in_beat),
        .char_valid (char_valid),
        .char_ready (char_ready),
        .char_beat  (char_beat)
    );

    zrl_run_encoder u_encoder (
        .clk        (clk),
        .rst        (rst),
        .char_valid (char_valid),
        .char_ready (char_ready),
        .char_beat  (char_beat),
        .byte_valid (byte_valid),
        .byte_ready (byte_ready),
        .byte_beat  (byte_beat)
    );

    zrl_byte_packer u_packer (
        .clk        (clk),
        .rst        (rst),
        .byte_valid (byte_valid),
        .byte_ready (byte_ready),
        .byte_beat  (byte_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_beat   (out_beat)
    );

endmodule

`default_nettype wire

/* tests/zrl_asserts.sv */
`default_nettype none

module zrl_asserts (
    input logic                      clk,
    input logic                      rst,
    input logic                      in_valid,
    input logic                      in_ready,
    input zrl_stream_pkg::in_beat_t  in_beat,
    input logic                      out_valid,
    input logic                      out_ready,
    input zrl_stream_pkg::out_beat_t out_beat
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    in_hold: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_beat))
    else begin
        $error("in_valid or in_beat changed before in_ready");
        fail_count++;
    end

    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else begin
        $error("out_valid or out_beat changed before out_ready");
        fail_count++;
    end

    keep_set: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_beat.keep != '0)
    else begin
        $error("out beat with empty keep");
        fail_count++;
    end

    rst_idle: assert property (@(posedge clk) rst |=> !out_valid)  // empty packer after reset
    else begin
        $error("out_valid high after reset");
        fail_count++;
    end

endmodule

bind zrl_coder_top zrl_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
);

`default_nettype wire

/* tests/zrl_checker.sv */
`default_nettype none

module zrl_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      out_valid,
    input  logic                      out_ready,
    input  zrl_stream_pkg::out_beat_t out_beat,
    output int                        error_count,
    output int                        frame_count,
    output int                        byte_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import zrl_stream_pkg::*;

    char_beat_t exp_q[$];

    task automatic add_expected(input char_beat_t e);
        exp_q.push_back(e);
    endtask

    always @(posedge clk) begin : compare_beat
        char_beat_t       want;
        logic [LANES-1:0] keep_inc;
        logic             got_last;
        int               top;
        if (rst) begin
            error_count = 0;
            frame_count = 0;
            byte_count  = 0;
        end else if (out_valid && out_ready) begin
            top      = -1;
            keep_inc = out_beat.keep + 1'b1;
            for (int i = 0; i < LANES; i++) begin
                if (out_beat.keep[i]) begin
                    top = i;
                end
            end
            // lanes fill from 0 upward, partial words only at frame end
            if ((out_beat.keep & keep_inc) != '0 || (!out_beat.last && out_beat.keep != '1)) begin
                $display("Error at %0d ns: bad keep %b with last %b",
                         $time, out_beat.keep, out_beat.last);
                error_count++;
            end
            for (int i = 0; i < LANES; i++) begin
                if (out_beat.keep[i]) begin
                    got_last = out_beat.last && (i == top);
                    byte_count++;
                    if (exp_q.size() == 0) begin
                        $display("Error at %0d ns: unexpected byte %02h in lane %0d",
                                 $time, out_beat.data[i], i);
                        error_count++;
                    end else begin
                        want = exp_q.pop_front();
                        if (want.ch != out_beat.data[i] || want.last != got_last) begin
                            $display("Error at %0d ns: expected %02h last %b, got %02h last %b",
                                     $time, want.ch, want.last, out_beat.data[i], got_last);
                            error_count++;
                        end
                    end
                end else if (out_beat.data[i] != '0) begin
                    $display("Error at %0d ns: unused lane %0d holds %02h, expected 00",
                             $time, i, out_beat.data[i]);
                    error_count++;
                end
            end
            if (out_beat.last) begin
                frame_count++;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/zrl_tb.sv */
`default_nettype none

module zrl_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import zrl_stream_pkg::*;
    import zrl_code_pkg::*;

    localparam logic [15:0] LFSR_SEED = 16'd96;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;  // x^16 + x^14 + x^13 + x^11 + 1
    localparam int RESET_CYCLES    = 16;
    localparam int LIT_FRAMES      = 4;
    localparam int MIX_FRAMES      = 60;
    localparam int LONG_WORDS      = 300;
    localparam int LONG_RUN_CYCLES = 2000;
    localparam int TIMEOUT_NS      = ((LIT_FRAMES + MIX_FRAMES) * 8 * 40 + LONG_RUN_CYCLES) * 20;
    localparam int MODE_MIX  = 0;
    localparam int MODE_LIT  = 1;
    localparam int MODE_ZERO = 2;

    logic       clk = 1'b0;
    logic       rst;
    logic       in_valid;
    logic       in_ready;
    in_beat_t   in_beat;
    logic       out_valid;
    logic       out_ready;
    out_beat_t  out_beat;
    logic [15:0] lfsr;
    logic       ready_random;
    logic       gap_random;
    int         frames_sent;
    int         exp_total;
    int         tb_errors;
    int         chk_errors;
    int         chk_frames;
    int         chk_bytes;
    char_t      frame_chars[$];
    char_beat_t frame_exp[$];

    always #10 clk = ~clk;

    zrl_coder_top u_zrl_coder_top (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

    zrl_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_beat    (out_beat),
        .error_count (chk_errors),
        .frame_count (chk_frames),
        .byte_count  (chk_bytes)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic char_t pick_char(input int mode);
        char_t c;
        if (mode == MODE_ZERO || (mode == MODE_MIX && draw_bits(2) != 0)) begin
            return ZERO_CHAR;
        end
        c = char_t'(draw_bits(8));
        return (c == ZERO_CHAR) ? (c ^ 8'h01) : c;  // anything but "0"
    endfunction

    task automatic push_token(input int run, input logic last);
        int n;
        n = run;
        frame_exp.push_back('{ch: ZERO_CHAR, last: 1'b0});
        do begin
            frame_exp.push_back('{ch: ZERO_CHAR + char_t'(n % 10), last: 1'b0});
            n = n / 10;
        end while (n > 0);
        frame_exp.push_back('{ch: RUN_END, last: last});
    endtask

    // reference coder for one frame
    task automatic encode_frame();
        int   run;
        logic at_end;
        run = 0;
        frame_exp.delete();
        for (int i = 0; i < frame_chars.size(); i++) begin
            at_end = i == frame_chars.size() - 1;
            if (frame_chars[i] == ZERO_CHAR) begin
                run++;
                if (run == RUN_MAX || at_end) begin
                    push_token(run, at_end);
                    run = 0;
                end
            end else begin
                if (run > 0) begin
                    push_token(run, 1'b0);
                    run = 0;
                end
                frame_exp.push_back('{ch: frame_chars[i], last: at_end});
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        out_ready = ready_random ? (draw_bits(2) != 0) : 1'b1;
    endtask

    task automatic send_word(input word_t data, input logic last);
        logic taken;
        while (gap_random && draw_bits(2) == 0) begin
            next_cycle();
        end
        in_valid = 1'b1;
        in_beat  = '{data: data, last: last};
        taken    = 1'b0;
        while (!taken) begin
            taken = in_ready;  // stable until the next rising edge
            next_cycle();
        end
        in_valid = 1'b0;
    endtask

    task automatic run_frame(input int nwords, input int mode);
        word_t data;
        frame_chars.delete();
        repeat (nwords * LANES) begin
            frame_chars.push_back(pick_char(mode));
        end
        encode_frame();
        foreach (frame_exp[i]) begin
            u_checker.add_expected(frame_exp[i]);
        end
        exp_total += frame_exp.size();
        for (int w = 0; w < nwords; w++) begin
            for (int k = 0; k < LANES; k++) begin
                data[k] = frame_chars[w * LANES + k];
            end
            send_word(data, w == nwords - 1);
        end
        frames_sent++;
    endtask

    // 1200 zeros give "0", then 0 0 2 1 units first, then the terminator
    task automatic check_long_token();
        char_t want [6] = '{8'h30, 8'h30, 8'h30, 8'h32, 8'h31, RUN_END};
        if (frame_exp.size() != 6) begin
            $display("Error at %0d ns: long run model gives %0d bytes, expected 6",
                     $time, frame_exp.size());
            tb_errors++;
        end else begin
            foreach (want[i]) begin
                if (frame_exp[i].ch != want[i] || frame_exp[i].last != (i == 5)) begin
                    $display("Error at %0d ns: long run byte %0d is %02h, expected %02h",
                             $time, i, frame_exp[i].ch, want[i]);
                    tb_errors++;
                end
            end
        end
    endtask

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: the output stream did not complete within %0d ns", TIMEOUT_NS);
        $display("Something failed");
        $finish;
    end

    initial begin : stimulus
        int total;
        lfsr         = LFSR_SEED;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_beat      = '0;
        out_ready    = 1'b0;
        ready_random = 1'b0;
        gap_random   = 1'b0;
        frames_sent  = 0;
        exp_total    = 0;
        tb_errors    = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        next_cycle();
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("Error at %0d ns: after reset out_valid=%b in_ready=%b, expected 0 and 1",
                     $time, out_valid, in_ready);
            tb_errors++;
        end
        for (int f = 0; f < LIT_FRAMES; f++) begin
            run_frame(draw_bits(3) + 1, MODE_LIT);
        end
        run_frame(LONG_WORDS, MODE_ZERO);
        check_long_token();
        ready_random = 1'b1;
        gap_random   = 1'b1;
        for (int f = 0; f < MIX_FRAMES; f++) begin
            run_frame(draw_bits(3) + 1, MODE_MIX);
        end
        while (chk_frames < frames_sent) begin
            next_cycle();
        end
        if (chk_bytes != exp_total) begin
            $display("Error at %0d ns: the DUT sent %0d bytes but the model expected %0d",
                     $time, chk_bytes, exp_total);
            tb_errors++;
        end
        total = chk_errors + tb_errors + u_zrl_coder_top.u_asserts.fail_count;
        $display("errors: checker %0d, testbench %0d, assertions %0d",
                 chk_errors, tb_errors, u_zrl_coder_top.u_asserts.fail_count);
        if (total == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hdl/zrl_stream_pkg.sv
hdl/zrl_code_pkg.sv
hdl/zrl_word_unpacker.sv
hdl/zrl_decimal_digits.sv
hdl/zrl_run_encoder.sv
hdl/zrl_byte_packer.sv
hdl/zrl_coder_top.sv
tests/zrl_asserts.sv
tests/zrl_checker.sv
tests/zrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the zero run-length coder testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module zrl_tb -f filelist.f -o zrl_sim

# the log decides the result, not the simulator exit status
./obj_dir/zrl_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
